/* Bender.yml */
package:
  name: huffman

sources:
  - huffman_pkg.sv
  - symbol_counter.sv
  - merge_engine.sv
  - code_builder.sv
  - huffman.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_huffman.sv

/* code_builder.sv */
// result stage of the huffman coder
// code and mask collection per merge, alignment to bit 0, sticky code_valid
`timescale 1ns/100ps
`default_nettype none

module code_builder (
	input  logic                     clk,
	input  logic                     reset,
	input  huffman_pkg::merge_t      merge,
	input  logic                     done,
	output logic                     code_valid,
	output huffman_pkg::code_array_t hc,
	output huffman_pkg::code_array_t m
);

	typedef enum logic [1:0] {
		S_COLLECT,
		S_ALIGN,
		S_HOLD
	} state_t;

	state_t                               state;
	logic [huffman_pkg::NUM_SYMBOLS-1:0] aligned;      // per symbol
	logic                                all_aligned;

	// new bit enters at the top, older bits move down
	function automatic logic [huffman_pkg::CODE_W-1:0] shift_in(
		input logic [huffman_pkg::CODE_W-1:0] word,
		input logic                           msb
	);
		return {msb, word[huffman_pkg::CODE_W-1:1]};
	endfunction

	always_comb begin
		for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
			aligned[k] = m[k][0] || (m[k] == '0);  // absent symbols count as aligned
		end
	end

	assign all_aligned = &aligned;
	assign code_valid  = (state == S_HOLD);

	// ========================================
	// phase control
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_COLLECT;
		end else begin
			case (state)
				S_COLLECT: begin
					if (done) begin
						state <= S_ALIGN;
					end
				end
				S_ALIGN: begin
					if (all_aligned) begin
						state <= S_HOLD;
					end
				end
				S_HOLD: state <= S_HOLD;  // until reset
				default: state <= S_COLLECT;
			endcase
		end
	end

	// ========================================
	// code words and masks
	always_ff @(posedge clk) begin
		if (reset) begin
			hc <= '0;
			m  <= '0;
		end else begin
			for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
				if ((state == S_COLLECT) && merge.valid) begin
					if (merge.one_set[k]) begin
						hc[k] <= shift_in(hc[k], 1'b1);
						m[k]  <= shift_in(m[k], 1'b1);
					end else if (merge.zero_set[k]) begin
						hc[k] <= shift_in(hc[k], 1'b0);
						m[k]  <= shift_in(m[k], 1'b1);
					end
				end else if ((state == S_ALIGN) && !aligned[k]) begin
					hc[k] <= shift_in(hc[k], 1'b0);  // toward bit 0
					m[k]  <= shift_in(m[k], 1'b0);
				end
			end
		end
	end

	for (genvar k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin : g_mask_chk
		a_mask_form: assert property (@(posedge clk) disable iff (reset)
			code_valid |-> (((m[k] & (m[k] + 1'b1)) == '0) && ((hc[k] & ~m[k]) == '0)));
	end

endmodule

`default_nettype wire

/* huffman.sv */
// top level of the six-symbol huffman coder
// symbol counter, merge engine and code builder in a chain
`timescale 1ns/100ps
`default_nettype none

module huffman (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [7:0]               gray_data,
	input  logic                     gray_valid,
	output logic                     cnt_valid,
	output huffman_pkg::cnt_array_t  cnt,
	output logic                     code_valid,
	output huffman_pkg::code_array_t hc,
	output huffman_pkg::code_array_t m
);

	huffman_pkg::merge_t merge;       // one merge per cycle
	logic                merge_done;  // tree complete

	symbol_counter u_counter (
		.clk        (clk),
		.reset      (reset),
		.gray_data  (gray_data),
		.gray_valid (gray_valid),
		.cnt_valid  (cnt_valid),
		.cnt        (cnt)
	);

	// the count report starts the tree build
	merge_engine u_merge (
		.clk   (clk),
		.reset (reset),
		.start (cnt_valid),
		.cnt   (cnt),
		.merge (merge),
		.done  (merge_done)
	);

	code_builder u_code (
		.clk        (clk),
		.reset      (reset),
		.merge      (merge),
		.done       (merge_done),
		.code_valid (code_valid),
		.hc         (hc),
		.m          (m)
	);

endmodule

`default_nettype wire

/* huffman_pkg.sv */
// shared widths and sizes of the six-symbol huffman coder
// node, merge and array types passed between the three stages
`default_nettype none

package huffman_pkg;

	// ========================================
	// sizes
	localparam int NUM_SYMBOLS = 6;  // symbols 1..6
	localparam int CNT_W       = 8;  // up to 255 symbols per frame
	localparam int CODE_W      = 8;  // code word and mask width
	localparam int SYM_FIELD_W = 3;  // symbol field at the bottom of gray_data

	// ========================================
	// types

	// bit k stands for symbol k+1
	typedef logic [NUM_SYMBOLS-1:0] sym_set_t;

	// one row of the node table
	typedef struct packed {
		logic [CNT_W-1:0] count;    // zero marks an empty row
		sym_set_t         members;  // symbols under this node
	} node_t;

	// symbol 1 in slot 0
	typedef logic [NUM_SYMBOLS-1:0][CNT_W-1:0] cnt_array_t;

	// code words and masks, symbol 1 in slot 0
	typedef logic [NUM_SYMBOLS-1:0][CODE_W-1:0] code_array_t;

	// one merge step from the execute stage to the result stage
	typedef struct packed {
		logic     valid;     // one cycle per merge
		sym_set_t one_set;   // lightest node, gets bit 1
		sym_set_t zero_set;  // second lightest, gets bit 0
	} merge_t;

endpackage

`default_nettype wire

/* merge_engine.sv */
// execute stage of the huffman coder
// node table, selection of the two lightest rows and one merge per cycle
`timescale 1ns/100ps
`default_nettype none

module merge_engine (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  huffman_pkg::cnt_array_t cnt,
	output huffman_pkg::merge_t     merge,
	output logic                    done
);

	huffman_pkg::node_t row [huffman_pkg::NUM_SYMBOLS];

	logic               busy;         // table loaded, merging
	int                 light_idx;
	int                 second_idx;
	logic               light_ok;
	logic               second_ok;
	logic               pair_ok;      // two nonempty rows left
	huffman_pkg::node_t light_node;
	huffman_pkg::node_t second_node;

	// smaller count first, on equal counts the larger member set
	function automatic logic lighter(
		input huffman_pkg::node_t a,
		input huffman_pkg::node_t b
	);
		return (a.count < b.count) ||
			((a.count == b.count) && (a.members > b.members));
	endfunction

	// ========================================
	// selection
	always_comb begin
		light_idx = 0;
		light_ok  = 1'b0;
		for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
			if ((row[k].count != '0) && (!light_ok || lighter(row[k], row[light_idx]))) begin
				light_idx = k;
				light_ok  = 1'b1;
			end
		end
	end

	always_comb begin
		second_idx = 0;
		second_ok  = 1'b0;
		for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
			if ((k != light_idx) && (row[k].count != '0) &&
				(!second_ok || lighter(row[k], row[second_idx]))) begin
				second_idx = k;
				second_ok  = 1'b1;
			end
		end
	end

	assign light_node  = row[light_idx];
	assign second_node = row[second_idx];
	assign pair_ok     = light_ok && second_ok;

	// ========================================
	// merge report
	always_comb begin
		merge.valid    = busy && pair_ok;
		merge.one_set  = light_node.members;
		merge.zero_set = second_node.members;
	end

	assign done = busy && !pair_ok;  // one row left, or none

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// ========================================
	// node table
	always_ff @(posedge clk) begin
		if (start) begin
			for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
				row[k].count   <= cnt[k];
				row[k].members <= huffman_pkg::sym_set_t'(1) << k;  // singleton
			end
		end else if (busy && pair_ok) begin
			// merged node takes the lighter row, the other row empties
			row[light_idx].count    <= light_node.count + second_node.count;
			row[light_idx].members  <= light_node.members | second_node.members;
			row[second_idx].count   <= '0;
			row[second_idx].members <= '0;
		end
	end

	// rows stay disjoint across all merges of a frame
	a_merge_sets: assert property (@(posedge clk) disable iff (reset)
		merge.valid |-> ((merge.one_set & merge.zero_set) == '0) &&
			(merge.one_set != '0) && (merge.zero_set != '0));

endmodule

`default_nettype wire

/* project.f */
+incdir+.
huffman_pkg.sv
symbol_counter.sv
merge_engine.sv
code_builder.sv
huffman.sv
tb_huffman.sv

/* symbol_counter.sv */
// decode stage of the huffman coder
// symbol counting and end-of-burst detection with the count report
`timescale 1ns/100ps
`default_nettype none

module symbol_counter (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [7:0]              gray_data,
	input  logic                    gray_valid,
	output logic                    cnt_valid,
	output huffman_pkg::cnt_array_t cnt
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RECV,
		S_DONE
	} state_t;

	state_t                              state;
	logic [huffman_pkg::SYM_FIELD_W-1:0] sym_field;
	logic                                counting;

	assign sym_field = gray_data[huffman_pkg::SYM_FIELD_W-1:0];  // upper bits carry nothing
	assign counting  = gray_valid && (state != S_DONE);        // later bursts ignored

	// ========================================
	// frame FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			cnt_valid <= 1'b0;
		end else begin
			cnt_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (gray_valid) begin
						state <= S_RECV;
					end
				end
				S_RECV: begin
					if (!gray_valid) begin  // burst over
						state     <= S_DONE;
						cnt_valid <= 1'b1;
					end
				end
				S_DONE: state <= S_DONE;    // held until reset
				default: state <= S_IDLE;
			endcase
		end
	end

	// values 0 and 7 match no slot
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (counting) begin
			for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
				if (sym_field == k + 1) begin
					cnt[k] <= cnt[k] + 1'b1;
				end
			end
		end
	end

	a_cnt_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |=> !cnt_valid);

endmodule

`default_nettype wire

/* tb_huffman_model.svh */
// reference model of the huffman coder for the testbench
// symbol counting, node ordering and code prediction from the merge rules
`ifndef TB_HUFFMAN_MODEL_SVH
`define TB_HUFFMAN_MODEL_SVH

// field 1..6 adds one, 0 and 7 are ignored
function automatic huffman_pkg::cnt_array_t count_symbol(
	input huffman_pkg::cnt_array_t c,
	input logic [7:0]              d
);
	huffman_pkg::cnt_array_t r;
	int                      s;
	r = c;
	s = d[huffman_pkg::SYM_FIELD_W-1:0];
	if (s >= 1 && s <= huffman_pkg::NUM_SYMBOLS) begin
		r[s-1] = r[s-1] + 1'b1;
	end
	return r;
endfunction

// smaller weight first, equal weights go to the larger set
function automatic bit ranks_lighter(
	input int                    wa,
	input huffman_pkg::sym_set_t sa,
	input int                    wb,
	input huffman_pkg::sym_set_t sb
);
	return (wa < wb) || ((wa == wb) && (sa > sb));
endfunction

task automatic predict_codes(
	input  huffman_pkg::cnt_array_t  c,
	output huffman_pkg::code_array_t hc_exp,
	output huffman_pkg::code_array_t m_exp
);
	int                    w [huffman_pkg::NUM_SYMBOLS];
	huffman_pkg::sym_set_t set [huffman_pkg::NUM_SYMBOLS];
	int                    len [huffman_pkg::NUM_SYMBOLS];
	int                    a;
	int                    b;
	hc_exp = '0;
	for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
		w[k]   = c[k];
		set[k] = huffman_pkg::sym_set_t'(1) << k;
		len[k] = 0;
	end
	for (int step = 0; step < huffman_pkg::NUM_SYMBOLS; step++) begin
		a = -1;  // lightest
		b = -1;  // second lightest
		for (int k = 0; k < huffman_pkg::NUM_SYMBOLS; k++) begin
			if (w[k] != 0) begin
				if (a < 0 || ranks_lighter(w[k], set[k], w[a], set[a])) begin
					b = a;
					a = k;
				end else if (b < 0 || ranks_lighter(w[k], set[k], w[b], set[b])) begin
					b = k;
				end
			end
		end
		if (b < 0) begin
			break;
		end
		for (int s = 0; s < huffman_pkg::NUM_SYMBOLS; s++) begin
			if (set[a][s] || set[b][s]) begin
				hc_exp[s][len[s]] = set[a][s];  // first merge lands in bit 0
				len[s]++;
			end
		end
		w[b]   = w[b] + w[a];
		set[b] = set[b] | set[a];
		w[a]   = 0;
	end
	for (int s = 0; s < huffman_pkg::NUM_SYMBOLS; s++) begin
		m_exp[s] = huffman_pkg::CODE_W'((1 << len[s]) - 1);
	end
endtask

`endif

/* tb_huffman.sv */
// testbench for the six-symbol huffman coder
// clock, reset, burst stimulus, assertions, watchdog and report
`timescale 1ns/100ps
`default_nettype none

module tb_huffman;

	localparam int CLK_NS = 4;
	localparam int LEN_1  = 50;  // burst lengths
	localparam int LEN_2  = 60;
	localparam int LEN_3  = 24;
	localparam int LEN_4  = 30;
	localparam int LEN_5  = 30;  // burst, ignored burst and second reset
	localparam int WATCHDOG_NS = (5 * (10 + 40) + LEN_1 + LEN_2 + LEN_3 + LEN_4 + LEN_5) * CLK_NS;

	logic                     clk;
	logic                     reset;
	logic [7:0]               gray_data;
	logic                     gray_valid;
	logic                     cnt_valid;
	logic                     code_valid;
	huffman_pkg::cnt_array_t  cnt;
	huffman_pkg::code_array_t hc;
	huffman_pkg::code_array_t m;

	huffman_pkg::cnt_array_t  exp_cnt;
	huffman_pkg::code_array_t exp_hc;
	huffman_pkg::code_array_t exp_m;
	integer                   seed;
	int                       errors;
	int                       pulses;  // cnt_valid pulses this frame
	int                       passed;
	int                       failed;

	`include "tb_huffman_model.svh"

	huffman uut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
	endtask

	// ========================================
	// assertions
	always @(posedge clk) begin
		if (!reset && cnt_valid) begin
			pulses++;
		end
	end

	a_cnt_report: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |-> (cnt == exp_cnt) && !$past(gray_valid) && $past(gray_valid, 2))
		else report_mismatch("count report wrong or not right after the burst");

	a_code_hold: assert property (@(posedge clk) disable iff (reset)
		code_valid |=> code_valid && $stable(hc) && $stable(m))
		else report_mismatch("code outputs moved while code_valid was high");

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run hung and was stopped after %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	// ========================================
	// stimulus
	function automatic logic [7:0] pick_symbol(input int mode, input int i);
		int unsigned r;
		r = $unsigned($random(seed));
		case (mode)
			0: return (i == 0) ? 8'h08 : (i == 1) ? 8'h07 : 8'(r);  // fields 0 and 7 early
			1: return (i < 6) ? 8'(i + 1) : 8'(r % 6 + 1);
			2: return 8'(i % 6 + 1);  // equal counts
			default: begin
				r = (i < 3) ? i : r % 3;
				return (r == 0) ? 8'd2 : (r == 1) ? 8'd3 : 8'd5;
			end
		endcase
	endfunction

	task automatic apply_reset();
		reset      = 1'b1;
		gray_valid = 1'b0;
		gray_data  = '0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		pulses  = 0;
		exp_cnt = '0;
		assert (!cnt_valid && !code_valid && cnt == '0 && hc == '0 && m == '0)
			else report_mismatch("outputs not cleared by reset");
	endtask

	task automatic send_burst(input int len, input int mode);
		for (int i = 0; i < len; i++) begin
			gray_valid = 1'b1;
			gray_data  = pick_symbol(mode, i);
			exp_cnt    = count_symbol(exp_cnt, gray_data);
			@(posedge clk);
			#1;
		end
		gray_valid = 1'b0;
		gray_data  = '0;
	endtask

	task automatic run_frame(input int len, input int mode);
		int n;
		apply_reset();
		send_burst(len, mode);
		predict_codes(exp_cnt, exp_hc, exp_m);
		n = 0;
		while (!code_valid && n < 40) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!code_valid) begin
			$display("code_valid never rose within 40 cycles after the burst");
			errors++;
		end
		assert (hc == exp_hc && m == exp_m) else report_mismatch($sformatf(
			"hc=%h m=%h, expected hc=%h m=%h", hc, m, exp_hc, exp_m));
		assert (pulses == 1) else report_mismatch("cnt_valid did not pulse exactly once");
	endtask

	function automatic bit codes_prefix_free(
		input huffman_pkg::code_array_t c,
		input huffman_pkg::code_array_t k
	);
		int la;
		int lb;
		for (int a = 0; a < huffman_pkg::NUM_SYMBOLS; a++) begin
			for (int b = 0; b < huffman_pkg::NUM_SYMBOLS; b++) begin
				la = $countones(k[a]);
				lb = $countones(k[b]);
				if (a != b && la != 0 && la <= lb && (c[b] >> (lb - la)) == c[a]) begin
					return 1'b0;  // root bits sit at the top of each code
				end
			end
		end
		return 1'b1;
	endfunction

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			passed++;
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: fail", name);
		end
	endtask

	// ========================================
	// tests
	initial begin
		int                      base;
		huffman_pkg::cnt_array_t keep;
		seed   = 97;
		errors = 0;
		passed = 0;
		failed = 0;
		pulses = 0;
		exp_cnt = '0;

		base = errors;
		run_frame(LEN_1, 0);
		finish_test("count report", base);

		base = errors;
		run_frame(LEN_2, 1);
		finish_test("random frame codes", base);

		base = errors;
		run_frame(LEN_3, 2);
		finish_test("tie rule", base);

		base = errors;
		run_frame(LEN_4, 3);
		assert (hc[0] == '0 && m[0] == '0 && hc[3] == '0 && m[3] == '0 &&
			hc[5] == '0 && m[5] == '0)
			else report_mismatch("absent symbols 1, 4 and 6 carry a code");
		assert (codes_prefix_free(hc, m)) else report_mismatch("codes are not prefix free");
		finish_test("absent symbols", base);

		base = errors;
		run_frame(12, 1);
		repeat (5) @(posedge clk);
		#1 keep = exp_cnt;
		send_burst(8, 2);  // second burst in the frame
		exp_cnt = keep;
		repeat (5) @(posedge clk);
		#1;
		assert (code_valid && cnt == exp_cnt && hc == exp_hc && m == exp_m)
			else report_mismatch("outputs changed after code_valid");
		assert (pulses == 1) else report_mismatch("cnt_valid pulsed again on the ignored burst");
		apply_reset();
		finish_test("reset and stickiness", base);

		$display("tests passed: %0d, failed: %0d, errors: %0d", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
